//--- src/um_pkg.sv
// um shared definitions
// packet word layout, word-kind codes, admission thresholds,
// local-bus address map, register reset values and shared types
`default_nettype none

package um_pkg;

	typedef logic [2:0]  word_kind_t;            // packet word kind
	typedef logic [3:0]  port_t;                 // input port number
	typedef logic [29:0] rule_t;                 // bit 29 set = packet from cdp
	typedef logic [31:0] lb_word_t;              // local-bus address/data word
	typedef logic [7:0]  usedw_t;                // packet fifo fill count
	typedef logic [4:0]  rule_usedw_t;           // rule fifo fill count

	// one 139-bit cdp word, msb first
	typedef struct packed {
		word_kind_t   kind;                      // head / tail / body marker
		logic [3:0]   rsvd;
		port_t        port;                      // valid on the head word
		logic [127:0] data;
	} cdp_word_t;

	typedef struct packed {
		logic     ale;                           // address latch enable
		logic     cs_n;                          // chip select, active low
		logic     rd_wr;                         // 1 read, 0 write
		lb_word_t data;                          // muxed address / write data
	} lb_req_t;

	// route table view of ram0..ram3
	typedef struct packed {
		port_t port_a;                           // ram0[3:0]
		rule_t rule_a;                           // ram1[29:0]
		port_t port_b;                           // ram2[3:0]
		rule_t rule_b;                           // ram3[29:0]
	} route_cfg_t;

	localparam int unsigned CDP_WORD_W = 139;    // matches $bits(cdp_word_t)

	localparam word_kind_t KIND_HEAD = 3'b101;   // first word of a packet
	localparam word_kind_t KIND_TAIL = 3'b110;   // last word of a packet

	localparam int unsigned FIFO_DEPTH       = 256;
	localparam usedw_t      FIFO_ADMIT_LIMIT = 8'd161; // room for a max-size packet
	localparam rule_usedw_t RULE_FIFO_LIMIT  = 5'd30;

	localparam logic [3:0] UM_SELECT  = 4'b0001; // address bits 31..28
	localparam logic [1:0] REGION_ID  = 2'b00;   // identification registers
	localparam logic [1:0] REGION_RAM = 2'b01;   // route registers

	// "UM", then version words
	localparam lb_word_t ID_RESET [0:7] = '{
		32'h554D, 32'h0609, 32'h0528, 32'h0526,
		32'h0, 32'h0, 32'h0, 32'h0
	};

	// default routes: port 1 -> rule 4, port 2 -> rule 2
	localparam lb_word_t RAM_RESET [0:7] = '{
		32'h1, 32'h4, 32'h2, 32'h2,
		32'h0, 32'h0, 32'h0, 32'h0
	};

	localparam rule_t RULE_DISCARD = 30'h0200_0000; // drop packets from unknown ports

endpackage

`default_nettype wire

//--- src/um_localbus_regs.sv
// um local-bus slave
// decodes the muxed ale/cs_n bus, holds the eight id and eight ram
// registers and exports the route table to the ingress side
`timescale 1ns/1ps
`default_nettype none

module um_localbus_regs (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire um_pkg::lb_req_t    lb,
	output logic                    localbus_ack_n,
	output um_pkg::lb_word_t        localbus_data_out,
	output um_pkg::route_cfg_t      route_cfg
);
	import um_pkg::*;

	typedef enum logic [2:0] {
		LB_IDLE,
		LB_ADDR,
		LB_WRITE,
		LB_READ,
		LB_ACK
	} lb_state_t;

	lb_state_t   state;
	logic [27:0] addr_q;                          // latched address below the select nibble
	lb_word_t    wr_data_q;                       // latched write data
	lb_word_t    id_bank  [0:7];
	lb_word_t    ram_bank [0:7];
	logic [1:0]  region;
	logic [7:0]  index;
	logic        index_ok;                        // index within the 8-entry banks
	lb_word_t    rd_value;

	assign region   = addr_q[27:26];
	assign index    = addr_q[7:0];
	assign index_ok = (index[7:3] == 5'd0);

	// read mux, unknown regions and indices give zero
	always_comb
	begin
		rd_value = '0;
		if (index_ok && region == REGION_ID)
			rd_value = id_bank[index[2:0]];
		else if (index_ok && region == REGION_RAM)
			rd_value = ram_bank[index[2:0]];
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state             <= LB_IDLE;
			addr_q            <= '0;
			wr_data_q         <= '0;
			localbus_ack_n    <= 1'b1;
			localbus_data_out <= '0;
			for (int i = 0; i < 8; i++)
			begin
				id_bank[i]  <= ID_RESET[i];
				ram_bank[i] <= RAM_RESET[i];
			end
		end
		else
		begin
			case (state)
				LB_IDLE:
					if (lb.ale && lb.data[31:28] == UM_SELECT) // address phase for this module
					begin
						addr_q <= lb.data[27:0];
						state  <= LB_ADDR;
					end
				LB_ADDR:
					if (!lb.cs_n && !lb.rd_wr)
					begin
						wr_data_q <= lb.data;  // data phase of a write
						state     <= LB_WRITE;
					end
					else if (!lb.cs_n && lb.rd_wr)
						state <= LB_READ;
				LB_WRITE:
				begin
					// id0..id3 are read only
					if (region == REGION_ID && index_ok && index[2])
						id_bank[index[2:0]] <= wr_data_q;
					else if (region == REGION_RAM && index_ok)
						ram_bank[index[2:0]] <= wr_data_q;
					localbus_ack_n <= 1'b0;    // ack every write, even ignored ones
					state          <= LB_ACK;
				end
				LB_READ:
				begin
					localbus_data_out <= rd_value;
					localbus_ack_n    <= 1'b0;
					state             <= LB_ACK;
				end
				LB_ACK:
					if (lb.cs_n)               // master has released the strobe
					begin
						localbus_ack_n <= 1'b1;
						state          <= LB_IDLE;
					end
				default:
				begin
					localbus_ack_n <= 1'b1;
					state          <= LB_IDLE;
				end
			endcase
		end
	end

	// route table taken straight from ram0..ram3
	assign route_cfg.port_a = ram_bank[0][3:0];
	assign route_cfg.rule_a = ram_bank[1][29:0];
	assign route_cfg.port_b = ram_bank[2][3:0];
	assign route_cfg.rule_b = ram_bank[3][29:0];

	// ack from a finished access must be gone before a new address is taken
	a_no_ack_in_idle: assert property (@(posedge clk) disable iff (!reset)
		(state == LB_IDLE) |-> localbus_ack_n);

endmodule

`default_nettype wire

//--- src/um_packet_fifo.sv
// um packet buffer
// single-clock circular fifo for cdp words with a show-ahead read port
`timescale 1ns/1ps
`default_nettype none

module um_packet_fifo (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               wr_en,
	input  wire um_pkg::cdp_word_t  wr_word,
	input  wire logic               rd_en,
	output um_pkg::cdp_word_t       rd_word,
	output logic                    empty,
	output um_pkg::usedw_t          usedw
);
	import um_pkg::*;

	logic [CDP_WORD_W-1:0]           mem [0:FIFO_DEPTH-1];
	logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]     count;      // one extra bit so full is visible
	logic                            full;

	assign full    = count[$clog2(FIFO_DEPTH)];
	assign empty   = (count == '0);
	assign usedw   = count[$clog2(FIFO_DEPTH)-1:0]; // wraps at full, like a vendor fifo
	assign rd_word = cdp_word_t'(mem[rd_ptr]);      // oldest word shown ahead

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;   // pointers wrap at the power-of-two depth
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // push and pop together keep the fill
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
		!(wr_en && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (!reset)
		!(rd_en && empty));

endmodule

`default_nettype wire

//--- src/um_ingress_ctrl.sv
// um ingress controller
// requests packets from the cdp input controller when there is room,
// and writes one forwarding rule per packet from the route table
`timescale 1ns/1ps
`default_nettype none

module um_ingress_ctrl (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  cdp2um_data_valid,
	input  wire um_pkg::cdp_word_t     cdp2um_data,
	input  wire um_pkg::usedw_t        fifo_usedw,
	input  wire um_pkg::rule_usedw_t   cdp2um_rule_usedw,
	input  wire um_pkg::route_cfg_t    route_cfg,
	output logic                       um2cdp_tx_enable,
	output um_pkg::rule_t              um2cdp_rule,
	output logic                       um2cdp_rule_wrreq
);
	import um_pkg::*;

	typedef enum logic {
		IN_IDLE,
		IN_REQ
	} in_state_t;

	in_state_t state;
	port_t     port_q;                          // port of the packet in flight
	logic      head_seen;
	logic      tail_seen;                       // tail with room in the rule fifo
	rule_t     rule_sel;

	assign head_seen = cdp2um_data_valid && (cdp2um_data.kind == KIND_HEAD);
	assign tail_seen = cdp2um_data_valid && (cdp2um_data.kind == KIND_TAIL)
		&& (cdp2um_rule_usedw < RULE_FIFO_LIMIT);

	// route lookup, port_a has priority over port_b
	always_comb
	begin
		if (port_q == route_cfg.port_a)
			rule_sel = route_cfg.rule_a;
		else if (port_q == route_cfg.port_b)
			rule_sel = route_cfg.rule_b;
		else
			rule_sel = RULE_DISCARD;
	end

	// tx_enable request fsm
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state            <= IN_IDLE;
			um2cdp_tx_enable <= 1'b0;
		end
		else
		begin
			case (state)
				IN_IDLE:
					// both fifos have room and the input side is between packets
					if (fifo_usedw < FIFO_ADMIT_LIMIT && cdp2um_rule_usedw < RULE_FIFO_LIMIT
						&& !cdp2um_data_valid)
					begin
						um2cdp_tx_enable <= 1'b1;
						state            <= IN_REQ;
					end
				IN_REQ:
					if (cdp2um_data_valid)     // packet has started, drop the request
					begin
						um2cdp_tx_enable <= 1'b0;
						state            <= IN_IDLE;
					end
				default:
				begin
					um2cdp_tx_enable <= 1'b0;
					state            <= IN_IDLE;
				end
			endcase
		end
	end

	// port latch and one-cycle rule write
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			port_q            <= '0;
			um2cdp_rule       <= '0;
			um2cdp_rule_wrreq <= 1'b0;
		end
		else
		begin
			if (head_seen)
				port_q <= cdp2um_data.port;
			if (tail_seen)
				um2cdp_rule <= rule_sel;   // rule held until the next packet
			um2cdp_rule_wrreq <= tail_seen;
		end
	end

	// a packet has at least a head and a tail, so rules never come back to back
	a_single_wrreq: assert property (@(posedge clk) disable iff (!reset)
		um2cdp_rule_wrreq |=> !um2cdp_rule_wrreq);

endmodule

`default_nettype wire

//--- src/um_egress_forward.sv
// um egress forwarder
// waits for the output controller, then pops one whole packet from
// the buffer fifo and drives it registered onto the cdp output
`timescale 1ns/1ps
`default_nettype none

module um_egress_forward (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               cdp2um_tx_enable,
	input  wire um_pkg::cdp_word_t  fifo_word,
	input  wire logic               fifo_empty,
	output logic                    fifo_rd,
	output logic                    um2cdp_data_valid,
	output um_pkg::cdp_word_t       um2cdp_data
);
	import um_pkg::*;

	typedef enum logic {
		EG_IDLE,
		EG_FWD
	} eg_state_t;

	eg_state_t state;

	// pop whenever a word is shown while forwarding, stall on empty
	assign fifo_rd = (state == EG_FWD) && !fifo_empty;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state             <= EG_IDLE;
			um2cdp_data_valid <= 1'b0;
		end
		else
		begin
			um2cdp_data_valid <= fifo_rd;  // popped word is valid next cycle
			case (state)
				EG_IDLE:
					if (cdp2um_tx_enable && !fifo_empty) // tx_enable only sampled here
						state <= EG_FWD;
				EG_FWD:
					if (fifo_rd && fifo_word.kind == KIND_TAIL)
						state <= EG_IDLE;   // packet done, wait for the next grant
				default:
					state <= EG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (fifo_rd)
			um2cdp_data <= fifo_word;      // words pass through unchanged
	end

endmodule

`default_nettype wire

//--- src/um_top.sv
// um user module top
// local-bus registers, packet buffer, ingress rule generation and
// egress forwarding between the cdp input and output controllers
`timescale 1ns/1ps
`default_nettype none

module um_top (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  localbus_cs_n,
	input  wire logic                  localbus_rd_wr,
	input  wire um_pkg::lb_word_t      localbus_data,
	input  wire logic                  localbus_ale,
	output logic                       localbus_ack_n,
	output um_pkg::lb_word_t           localbus_data_out,
	output logic                       um2cdp_path,
	input  wire logic                  cdp2um_data_valid,
	input  wire um_pkg::cdp_word_t     cdp2um_data,
	output logic                       um2cdp_tx_enable,
	output logic                       um2cdp_data_valid,
	output um_pkg::cdp_word_t          um2cdp_data,
	input  wire logic                  cdp2um_tx_enable,
	output um_pkg::rule_t              um2cdp_rule,
	output logic                       um2cdp_rule_wrreq,
	input  wire um_pkg::rule_usedw_t   cdp2um_rule_usedw
);
	import um_pkg::*;

	lb_req_t    lb_req;
	route_cfg_t route_cfg;
	cdp_word_t  fifo_word;                      // show-ahead head of the buffer
	logic       fifo_empty;
	logic       fifo_rd;
	usedw_t     fifo_usedw;

	assign lb_req = '{ale: localbus_ale, cs_n: localbus_cs_n,
		rd_wr: localbus_rd_wr, data: localbus_data};

	assign um2cdp_path = um2cdp_rule[29];      // 1 = packet came from cdp

	um_localbus_regs u_regs (
		.clk               (clk),
		.reset             (reset),
		.lb                (lb_req),
		.localbus_ack_n    (localbus_ack_n),
		.localbus_data_out (localbus_data_out),
		.route_cfg         (route_cfg)
	);

	// every valid input word is buffered
	um_packet_fifo u_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (cdp2um_data_valid),
		.wr_word (cdp2um_data),
		.rd_en   (fifo_rd),
		.rd_word (fifo_word),
		.empty   (fifo_empty),
		.usedw   (fifo_usedw)
	);

	um_ingress_ctrl u_ingress (
		.clk               (clk),
		.reset             (reset),
		.cdp2um_data_valid (cdp2um_data_valid),
		.cdp2um_data       (cdp2um_data),
		.fifo_usedw        (fifo_usedw),
		.cdp2um_rule_usedw (cdp2um_rule_usedw),
		.route_cfg         (route_cfg),
		.um2cdp_tx_enable  (um2cdp_tx_enable),
		.um2cdp_rule       (um2cdp_rule),
		.um2cdp_rule_wrreq (um2cdp_rule_wrreq)
	);

	um_egress_forward u_egress (
		.clk               (clk),
		.reset             (reset),
		.cdp2um_tx_enable  (cdp2um_tx_enable),
		.fifo_word         (fifo_word),
		.fifo_empty        (fifo_empty),
		.fifo_rd           (fifo_rd),
		.um2cdp_data_valid (um2cdp_data_valid),
		.um2cdp_data       (um2cdp_data)
	);

endmodule

`default_nettype wire

//--- verification/um_tb.sv
// um testbench
// runs register accesses and packets from the vectors file through um_top,
// checks register reads, forwarding rules, the tx_enable handshake and
// the forwarded word stream
`timescale 1ns/1ps
`default_nettype none

module um_tb;
	import um_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int IDLE_WINDOW  = 16;               // cycles watched for absent events
	localparam int CYC_PER_VEC  = 200;

	logic        clk;
	logic        reset;
	logic        localbus_cs_n;
	logic        localbus_rd_wr;
	lb_word_t    localbus_data;
	logic        localbus_ale;
	logic        localbus_ack_n;
	lb_word_t    localbus_data_out;
	logic        um2cdp_path;
	logic        cdp2um_data_valid;
	cdp_word_t   cdp2um_data;
	logic        um2cdp_tx_enable;
	logic        um2cdp_data_valid;
	cdp_word_t   um2cdp_data;
	logic        cdp2um_tx_enable;
	rule_t       um2cdp_rule;
	logic        um2cdp_rule_wrreq;
	rule_usedw_t cdp2um_rule_usedw;

	logic [7:0]  vec_op [$];                        // W, R or P
	logic [31:0] vec_a [$];
	logic [31:0] vec_b [$];
	logic [31:0] vec_c [$];
	logic [31:0] vec_d [$];
	int          n_vec = 0;
	int          errors = 0;
	int          checks = 0;
	int          rule_count = 0;                    // rule write pulses seen
	rule_t       last_rule;
	logic        last_path;                         // path seen with the last rule write
	cdp_word_t   out_q [$];                         // words seen on the output
	cdp_word_t   exp_q [$];
	logic        tx_prev = 1'b0;
	logic        valid_prev = 1'b0;
	logic        wrreq_prev = 1'b0;
	rule_usedw_t usedw_prev = '0;

	um_top u_dut (
		.clk               (clk),
		.reset             (reset),
		.localbus_cs_n     (localbus_cs_n),
		.localbus_rd_wr    (localbus_rd_wr),
		.localbus_data     (localbus_data),
		.localbus_ale      (localbus_ale),
		.localbus_ack_n    (localbus_ack_n),
		.localbus_data_out (localbus_data_out),
		.um2cdp_path       (um2cdp_path),
		.cdp2um_data_valid (cdp2um_data_valid),
		.cdp2um_data       (cdp2um_data),
		.um2cdp_tx_enable  (um2cdp_tx_enable),
		.um2cdp_data_valid (um2cdp_data_valid),
		.um2cdp_data       (um2cdp_data),
		.cdp2um_tx_enable  (cdp2um_tx_enable),
		.um2cdp_rule       (um2cdp_rule),
		.um2cdp_rule_wrreq (um2cdp_rule_wrreq),
		.cdp2um_rule_usedw (cdp2um_rule_usedw)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [159:0] actual,
		input logic [159:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected,
				$time);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	// wait until ack_n reaches level, sampled just after each edge
	task automatic wait_ack(input logic level, output logic ok);
		int n = 0;
		ok = 1'b0;
		while (!ok && n < 20)
		begin
			@(posedge clk);
			#1;
			ok = (localbus_ack_n == level);
			n++;
		end
	endtask

	// one address phase, one data phase, then ack handshake
	task automatic bus_access(input logic rd, input logic [31:0] region,
		input logic [31:0] index, input logic [31:0] wdata, output lb_word_t rdata);
		logic ok;
		@(posedge clk);
		#1;
		localbus_ale  = 1'b1;
		localbus_data = {4'b0001, region[1:0], 18'd0, index[7:0]}; // select nibble 1
		@(posedge clk);
		#1;
		localbus_ale   = 1'b0;
		localbus_cs_n  = 1'b0;
		localbus_rd_wr = rd;
		localbus_data  = rd ? 32'd0 : wdata;
		wait_ack(1'b0, ok);
		if (!ok)
			report_error("local bus access was not acknowledged");
		rdata = localbus_data_out;                  // loaded together with ack
		localbus_cs_n  = 1'b1;
		localbus_rd_wr = 1'b0;
		wait_ack(1'b1, ok);
		if (!ok)
			report_error("local bus ack_n was not released after cs_n went high");
	endtask

	task automatic send_packet(input logic [31:0] port, input int len,
		input logic [31:0] usedw, input logic [31:0] rule);
		cdp_word_t w;
		int        n = 0;
		int        rules_before;
		logic      blocked;
		logic      tx_seen = 1'b0;
		@(posedge clk);
		#1;
		cdp2um_rule_usedw = usedw[4:0];
		cdp2um_tx_enable  = 1'b0;                   // output side held off for now
		blocked = (usedw[4:0] >= RULE_FIFO_LIMIT);
		if (!blocked)
		begin
			while (!um2cdp_tx_enable && n < 20)
			begin
				@(posedge clk);
				#1;
				n++;
			end
			if (!um2cdp_tx_enable)
				report_error("um2cdp_tx_enable never rose for a new packet");
		end
		rules_before = rule_count;
		exp_q.delete();
		out_q.delete();
		for (int i = 0; i < len; i++)
		begin
			w.kind = (i == 0) ? KIND_HEAD : (i == len - 1) ? KIND_TAIL : 3'b100;
			w.rsvd = 4'd0;
			w.port = port[3:0];
			w.data = {$urandom, $urandom, $urandom, $urandom};
			cdp2um_data       = w;
			cdp2um_data_valid = 1'b1;
			exp_q.push_back(w);
			@(posedge clk);
			#1;
		end
		cdp2um_data_valid = 1'b0;
		if (blocked)
		begin
			// rule fifo full, no request and no rule may follow
			for (int i = 0; i < IDLE_WINDOW; i++)
			begin
				@(posedge clk);
				#1;
				if (um2cdp_tx_enable)
					tx_seen = 1'b1;
			end
			check_value("um2cdp_tx_enable while rule fifo full", 160'(tx_seen), 160'(0));
			check_value("um2cdp_rule_wrreq pulses", 160'(rule_count), 160'(rules_before));
		end
		else
		begin
			n = 0;
			while (rule_count == rules_before && n < 10)
			begin
				@(posedge clk);
				#1;
				n++;
			end
			repeat (2) @(posedge clk);
			#1;
			check_value("um2cdp_rule_wrreq pulses", 160'(rule_count), 160'(rules_before + 1));
			check_value("um2cdp_rule", 160'(last_rule), 160'(rule[29:0]));
			check_value("um2cdp_path", 160'(last_path), 160'(rule[29]));
		end
		repeat (4) @(posedge clk);
		#1;
		check_value("um2cdp_data_valid words with tx_enable low", 160'(out_q.size()), 160'(0));
		cdp2um_tx_enable = 1'b1;
		n = 0;
		while (out_q.size() < len && n < 4 * len + 20)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		cdp2um_tx_enable = 1'b0;
		repeat (2) @(posedge clk);                  // catch any extra word
		#1;
		check_value("um2cdp_data word count", 160'(out_q.size()), 160'(len));
		for (int i = 0; i < len && i < out_q.size(); i++)
			check_value("um2cdp_data", 160'(out_q[i]), 160'(exp_q[i]));
	endtask

	// output capture and handshake rules, sampled mid-cycle
	always @(negedge clk)
	begin
		if (reset)
		begin
			if (um2cdp_data_valid)
				out_q.push_back(um2cdp_data);
			if (um2cdp_rule_wrreq)
			begin
				rule_count++;
				last_rule = um2cdp_rule;
				last_path = um2cdp_path;
				if (wrreq_prev)
					report_error("um2cdp_rule_wrreq was high on two cycles in a row");
			end
			if (um2cdp_tx_enable && !tx_prev && valid_prev)
				report_error("um2cdp_tx_enable rose while cdp2um_data_valid was high");
			if (um2cdp_tx_enable && !tx_prev && usedw_prev >= RULE_FIFO_LIMIT)
				report_error("um2cdp_tx_enable rose while the rule fifo was full");
			if (um2cdp_tx_enable && tx_prev && valid_prev)
				report_error("um2cdp_tx_enable stayed high after data_valid was seen");
		end
		tx_prev    = um2cdp_tx_enable;
		valid_prev = cdp2um_data_valid;
		usedw_prev = cdp2um_rule_usedw;
		wrreq_prev = um2cdp_rule_wrreq;
	end

	// watchdog sized from the vector count
	initial
	begin
		wait (n_vec != 0);
		repeat (n_vec * CYC_PER_VEC) @(posedge clk);
		$display("TIMEOUT: the run did not finish within %0d cycles", n_vec * CYC_PER_VEC);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		int               fd;
		int               code;
		int               ch;
		logic [7:0]       op;
		logic [8*256-1:0] line;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		logic [31:0]      d;
		lb_word_t         rdata;
		void'($urandom(32'h55ea_25d0));
		reset             = 1'b0;
		localbus_cs_n     = 1'b1;
		localbus_rd_wr    = 1'b0;
		localbus_data     = '0;
		localbus_ale      = 1'b0;
		cdp2um_data_valid = 1'b0;
		cdp2um_data       = '0;
		cdp2um_tx_enable  = 1'b0;
		cdp2um_rule_usedw = '0;
		fd = $fopen("verification/um_vectors.txt", "r");
		if (fd == 0)
			report_error("cannot open verification/um_vectors.txt");
		else
		begin
			ch = $fgetc(fd);
			while (ch != -1)
			begin
				op = 8'(ch);
				d  = '0;
				if (op == "#")
					code = $fgets(line, fd);    // comment line
				else if (op == "W" || op == "R" || op == "P")
				begin
					if (op == "P")
						code = $fscanf(fd, "%h %d %d %h", a, b, c, d) - 1;
					else
						code = $fscanf(fd, "%h %h %h", a, b, c);
					if (code != 3)
						report_error("malformed line in the vectors file");
					vec_op.push_back(op);
					vec_a.push_back(a);
					vec_b.push_back(b);
					vec_c.push_back(c);
					vec_d.push_back(d);
				end
				ch = $fgetc(fd);
			end
			$fclose(fd);
			if (vec_op.size() == 0)
				report_error("the vectors file holds no vectors");
		end
		n_vec = vec_op.size();
		repeat (5) @(posedge clk);
		#1;
		check_value("um2cdp_tx_enable", 160'(um2cdp_tx_enable), 160'(0));
		check_value("um2cdp_data_valid", 160'(um2cdp_data_valid), 160'(0));
		check_value("um2cdp_rule_wrreq", 160'(um2cdp_rule_wrreq), 160'(0));
		check_value("um2cdp_path", 160'(um2cdp_path), 160'(0));
		check_value("localbus_ack_n", 160'(localbus_ack_n), 160'(1));
		check_value("um2cdp_rule", 160'(um2cdp_rule), 160'(0));
		check_value("localbus_data_out", 160'(localbus_data_out), 160'(0));
		reset = 1'b1;
		for (int i = 0; i < n_vec; i++)
		begin
			if (vec_op[i] == "W")
				bus_access(1'b0, vec_a[i], vec_b[i], vec_c[i], rdata);
			else if (vec_op[i] == "R")
			begin
				bus_access(1'b1, vec_a[i], vec_b[i], 32'd0, rdata);
				check_value($sformatf("localbus_data_out (region %0h index %0h)",
					vec_a[i][1:0], vec_b[i][7:0]), 160'(rdata), 160'(vec_c[i]));
			end
			else
				send_packet(vec_a[i], int'(vec_b[i]), vec_c[i], vec_d[i]);
		end
		$display("vectors: %0d, checks: %0d, errors: %0d", n_vec, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
src/um_pkg.sv
src/um_localbus_regs.sv
src/um_packet_fifo.sv
src/um_ingress_ctrl.sv
src/um_egress_forward.sv
src/um_top.sv
verification/um_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the um testbench with Verilator, run it, and scan the log for failure

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module um_tb -Mdir obj_dir \
	-f src.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/Vum_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$SIM_LOG"; then
	exit 1
fi
exit 0

//--- verification/um_vectors.txt
# W region index data | R region index expected (all hex)
# P port(hex) words(dec) rule_usedw(dec) expected_rule(hex), no rule when rule_usedw >= 30
R 0 00 0000554d
R 0 01 00000609
R 0 02 00000528
R 0 03 00000526
R 0 04 00000000
R 0 05 00000000
R 0 06 00000000
R 0 07 00000000
R 1 00 00000001
R 1 01 00000004
R 1 02 00000002
R 1 03 00000002
R 1 04 00000000
R 1 05 00000000
R 1 06 00000000
R 1 07 00000000
W 0 04 cafe0004
R 0 04 cafe0004
W 0 07 0badf00d
R 0 07 0badf00d
W 0 00 12345678
R 0 00 0000554d
W 1 06 a5a5a5a5
R 1 06 a5a5a5a5
W 2 00 ffffffff
R 2 00 00000000
W 1 10 11111111
R 1 10 00000000
P 1 4 0 00000004
P 2 3 0 00000002
P 7 5 0 02000000
P 1 2 30 00000000
P 2 2 29 00000002
W 1 00 00000005
W 1 01 20000011
W 1 02 00000009
W 1 03 00000033
P 5 4 0 20000011
P 9 3 0 00000033
P 1 2 0 02000000
